/* design/adc_macros.svh */
`ifndef ADC_MACROS_SVH
`define ADC_MACROS_SVH

// converter widths
`define ADC_NADC    8
`define ADC_NTAPS   255
`define ADC_CODE_W  9

// axi4-lite port widths
`define ADC_AXI_AW  4
`define ADC_AXI_DW  32

// register byte offsets
// CTRL layout: en bit 0, phase_reverse bit 1, avg_log2 bits 4:2, avg_done bit 31
`define ADC_REG_CTRL    4'h0
`define ADC_REG_OFFSET  4'h4
`define ADC_REG_SAMPLE  4'h8
`define ADC_REG_AVG     4'hC

`endif

/* design/adc_pkg.sv */
`include "adc_macros.svh"

package adc_pkg;

    // word index of each register, i.e. byte offset >> 2
    typedef enum logic [1:0] {
        CSR_CTRL   = 2'(`ADC_REG_CTRL >> 2),
        CSR_OFFSET = 2'(`ADC_REG_OFFSET >> 2),
        CSR_SAMPLE = 2'(`ADC_REG_SAMPLE >> 2),
        CSR_AVG    = 2'(`ADC_REG_AVG >> 2)
    } csr_addr_e;

    typedef enum logic {
        AXI_IDLE = 1'b0,
        AXI_RESP = 1'b1   // response pending
    } axi_state_e;

    typedef struct packed {
        logic                           en;
        logic                           phase_reverse;
        logic [2:0]                     avg_log2;   // block of 2^n samples
        logic signed [`ADC_CODE_W-1:0]  offset;
    } adc_cfg_t;

    typedef struct packed {
        logic                   valid;
        logic                   sign;
        logic [`ADC_NADC-1:0]   mag;
    } tdc_count_t;

    typedef struct packed {
        logic                           valid;
        logic signed [`ADC_CODE_W-1:0]  code;
    } adc_sample_t;

    typedef struct packed {
        logic signed [`ADC_CODE_W-1:0]  last_code;
        logic signed [`ADC_CODE_W-1:0]  avg;
        logic                           avg_done;   // sticky until CTRL write
        logic [15:0]                    count;
    } adc_status_t;

endpackage

/* design/tdc_decode.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module tdc_decode (
    input  logic                    clk_adder,
    input  logic                    rstb,
    input  logic [`ADC_NTAPS-1:0]   taps,
    input  logic                    sign,
    input  logic                    valid,
    input  adc_pkg::adc_cfg_t       cfg,
    output adc_pkg::tdc_count_t     count
);

    localparam int GRP_W  = 16;
    localparam int NGRP   = (`ADC_NTAPS + GRP_W) / GRP_W;   // 16 groups cover 256 bits
    localparam int PAD_W  = NGRP * GRP_W;
    localparam int PSUM_W = $clog2(GRP_W + 1);

    logic                   pr_meta;
    logic                   pr_sync;
    logic [PAD_W-1:0]       taps_pad;
    logic [PSUM_W-1:0]      psum_d [NGRP];
    logic [PSUM_W-1:0]      psum_q [NGRP];
    logic                   s1_valid;
    logic                   s1_sign;
    logic [`ADC_NADC-1:0]   total_d;
    logic                   s2_valid;
    logic                   s2_sign;
    logic [`ADC_NADC-1:0]   s2_mag;

    // phase reverse flips the snapshot so the zeros get counted
    assign taps_pad = {(PAD_W - `ADC_NTAPS)'(0), taps ^ {`ADC_NTAPS{pr_sync}}};

    always_comb begin
        for (int g = 0; g < NGRP; g++) begin
            psum_d[g] = '0;
            for (int b = 0; b < GRP_W; b++) begin
                psum_d[g] = psum_d[g] + PSUM_W'(taps_pad[g*GRP_W + b]);
            end
        end
    end

    always_comb begin
        total_d = '0;
        for (int g = 0; g < NGRP; g++) begin
            total_d = total_d + `ADC_NADC'(psum_q[g]);
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            pr_meta  <= 1'b0;
            pr_sync  <= 1'b0;
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            pr_meta  <= cfg.phase_reverse;
            pr_sync  <= pr_meta;
            s1_valid <= valid & cfg.en;   // conversions dropped while disabled
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_adder) begin
        psum_q  <= psum_d;
        s1_sign <= sign;
        s2_sign <= s1_sign;
        s2_mag  <= total_d;
    end

    assign count = '{valid: s2_valid, sign: s2_sign, mag: s2_mag};

endmodule

/* design/code_execute.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module code_execute (
    input  logic                    clk_adder,
    input  logic                    rstb,
    input  adc_pkg::tdc_count_t     count,
    input  adc_pkg::adc_cfg_t       cfg,
    output adc_pkg::adc_sample_t    sample
);

    // two guard bits hold +-255 minus a 9-bit offset
    localparam int WIDE_W = `ADC_CODE_W + 2;
    localparam logic signed [WIDE_W-1:0] CODE_MAX = WIDE_W'((2 ** (`ADC_CODE_W - 1)) - 1);
    localparam logic signed [WIDE_W-1:0] CODE_MIN = WIDE_W'(-(2 ** (`ADC_CODE_W - 1)));

    logic signed [WIDE_W-1:0]       mag_s;
    logic signed [WIDE_W-1:0]       off_s;
    logic signed [WIDE_W-1:0]       raw;
    logic signed [WIDE_W-1:0]       sat;
    logic                           valid_q;
    logic signed [`ADC_CODE_W-1:0]  code_q;

    always_comb begin
        mag_s = signed'(WIDE_W'(count.mag));
        off_s = WIDE_W'(cfg.offset);            // sign extends
        raw   = (count.sign ? mag_s : -mag_s) - off_s;
        if (raw > CODE_MAX) begin
            sat = CODE_MAX;
        end else if (raw < CODE_MIN) begin
            sat = CODE_MIN;
        end else begin
            sat = raw;
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= count.valid;
        end
    end

    always_ff @(posedge clk_adder) begin
        code_q <= sat[`ADC_CODE_W-1:0];
    end

    assign sample = '{valid: valid_q, code: code_q};

endmodule

/* design/result_stage.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module result_stage (
    input  logic                    clk_adder,
    input  logic                    rstb,
    input  adc_pkg::adc_sample_t    sample,
    input  adc_pkg::adc_cfg_t       cfg,
    input  logic                    clear,
    output adc_pkg::adc_status_t    status
);

    localparam int ACC_W = `ADC_CODE_W + 8;   // up to 128 codes

    logic signed [ACC_W-1:0]        acc;
    logic signed [ACC_W-1:0]        acc_next;
    logic [6:0]                     blk_cnt;
    logic [6:0]                     blk_last;
    logic signed [`ADC_CODE_W-1:0]  last_code;
    logic signed [`ADC_CODE_W-1:0]  avg;
    logic                           avg_done;
    logic [15:0]                    smp_count;

    always_comb begin
        acc_next = acc + ACC_W'(sample.code);
        blk_last = 7'((8'd1 << cfg.avg_log2) - 8'd1);
    end

    // last code survives a clear so SAMPLE keeps reading it
    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            last_code <= '0;
        end else if (sample.valid) begin
            last_code <= sample.code;
        end
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            acc       <= '0;
            blk_cnt   <= '0;
            avg       <= '0;
            avg_done  <= 1'b0;
            smp_count <= '0;
        end else if (clear) begin
            acc       <= '0;
            blk_cnt   <= '0;
            avg_done  <= 1'b0;
            smp_count <= '0;
        end else if (sample.valid) begin
            if (smp_count != 16'hFFFF) begin
                smp_count <= smp_count + 16'd1;
            end
            if (blk_cnt >= blk_last) begin
                // floor average, block restarts
                avg      <= `ADC_CODE_W'(acc_next >>> cfg.avg_log2);
                acc      <= '0;
                blk_cnt  <= '0;
                avg_done <= 1'b1;
            end else begin
                acc     <= acc_next;
                blk_cnt <= blk_cnt + 7'd1;
            end
        end
    end

    assign status = '{last_code: last_code, avg: avg, avg_done: avg_done, count: smp_count};

endmodule

/* design/csr_axil.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module csr_axil (
    input  logic                        clk_adder,
    input  logic                        rstb,
    input  logic [`ADC_AXI_AW-1:0]      awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`ADC_AXI_DW-1:0]      wdata,
    input  logic [`ADC_AXI_DW/8-1:0]    wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`ADC_AXI_AW-1:0]      araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`ADC_AXI_DW-1:0]      rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready,
    output adc_pkg::adc_cfg_t           cfg,
    output logic                        clear,
    input  adc_pkg::adc_status_t        status
);

    adc_pkg::axi_state_e        wr_state;
    adc_pkg::axi_state_e        rd_state;
    adc_pkg::csr_addr_e         wr_word;
    adc_pkg::csr_addr_e         rd_word;
    adc_pkg::adc_cfg_t          cfg_q;
    logic                       clear_q;
    logic [`ADC_AXI_DW-1:0]     rd_mux;
    logic [`ADC_AXI_DW-1:0]     rdata_q;

    // aw and w taken together, nothing new while a response waits
    assign awready = (wr_state == adc_pkg::AXI_IDLE) && awvalid && wvalid;
    assign wready  = awready;
    assign bvalid  = (wr_state == adc_pkg::AXI_RESP);
    assign bresp   = 2'b00;
    assign wr_word = adc_pkg::csr_addr_e'(awaddr[`ADC_AXI_AW-1:2]);

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            wr_state <= adc_pkg::AXI_IDLE;
            cfg_q    <= '0;
            clear_q  <= 1'b0;
        end else begin
            clear_q <= 1'b0;
            case (wr_state)
                adc_pkg::AXI_IDLE: begin
                    if (awready) begin
                        wr_state <= adc_pkg::AXI_RESP;
                        case (wr_word)
                            adc_pkg::CSR_CTRL: begin
                                if (wstrb[0]) begin
                                    cfg_q.en            <= wdata[0];
                                    cfg_q.phase_reverse <= wdata[1];
                                    cfg_q.avg_log2      <= wdata[4:2];
                                    clear_q             <= 1'b1;
                                end
                            end
                            adc_pkg::CSR_OFFSET: begin
                                if (wstrb[0]) cfg_q.offset[7:0] <= wdata[7:0];
                                if (wstrb[1]) begin
                                    cfg_q.offset[`ADC_CODE_W-1:8] <= wdata[`ADC_CODE_W-1:8];
                                end
                            end
                            default: ;  // SAMPLE and AVG are read only
                        endcase
                    end
                end
                adc_pkg::AXI_RESP: begin
                    if (bready) wr_state <= adc_pkg::AXI_IDLE;
                end
                default: wr_state <= adc_pkg::AXI_IDLE;
            endcase
        end
    end

    assign arready = (rd_state == adc_pkg::AXI_IDLE) && arvalid;
    assign rvalid  = (rd_state == adc_pkg::AXI_RESP);
    assign rresp   = 2'b00;
    assign rd_word = adc_pkg::csr_addr_e'(araddr[`ADC_AXI_AW-1:2]);

    always_comb begin
        case (rd_word)
            adc_pkg::CSR_CTRL: begin
                rd_mux = {status.avg_done, (`ADC_AXI_DW - 6)'(0), cfg_q.avg_log2,
                          cfg_q.phase_reverse, cfg_q.en};
            end
            adc_pkg::CSR_OFFSET: rd_mux = `ADC_AXI_DW'(cfg_q.offset);
            adc_pkg::CSR_SAMPLE: rd_mux = `ADC_AXI_DW'(status.last_code);
            default:             rd_mux = `ADC_AXI_DW'(status.avg);
        endcase
    end

    always_ff @(posedge clk_adder or negedge rstb) begin
        if (!rstb) begin
            rd_state <= adc_pkg::AXI_IDLE;
        end else if (rd_state == adc_pkg::AXI_IDLE) begin
            if (arready) rd_state <= adc_pkg::AXI_RESP;
        end else if (rready) begin
            rd_state <= adc_pkg::AXI_IDLE;
        end
    end

    // held stable while rvalid is up
    always_ff @(posedge clk_adder) begin
        if (arready) rdata_q <= rd_mux;
    end

    assign rdata = rdata_q;
    assign cfg   = cfg_q;
    assign clear = clear_q;

endmodule

/* design/adc_backend_top.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module adc_backend_top (
    input  logic                        clk_adder,
    input  logic                        rstb,
    input  logic [`ADC_NTAPS-1:0]       tdc_taps,
    input  logic                        pfd_sign,
    input  logic                        tdc_valid,
    output adc_pkg::adc_sample_t        sample,
    input  logic [`ADC_AXI_AW-1:0]      awaddr,
    input  logic                        awvalid,
    output logic                        awready,
    input  logic [`ADC_AXI_DW-1:0]      wdata,
    input  logic [`ADC_AXI_DW/8-1:0]    wstrb,
    input  logic                        wvalid,
    output logic                        wready,
    output logic [1:0]                  bresp,
    output logic                        bvalid,
    input  logic                        bready,
    input  logic [`ADC_AXI_AW-1:0]      araddr,
    input  logic                        arvalid,
    output logic                        arready,
    output logic [`ADC_AXI_DW-1:0]      rdata,
    output logic [1:0]                  rresp,
    output logic                        rvalid,
    input  logic                        rready
);

    adc_pkg::adc_cfg_t      cfg;
    adc_pkg::tdc_count_t    tdc_count;
    adc_pkg::adc_status_t   status;
    logic                   clear;

    tdc_decode u_decode (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .taps      (tdc_taps),
        .sign      (pfd_sign),
        .valid     (tdc_valid),
        .cfg       (cfg),
        .count     (tdc_count)
    );

    code_execute u_execute (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .count     (tdc_count),
        .cfg       (cfg),
        .sample    (sample)
    );

    result_stage u_result (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .sample    (sample),
        .cfg       (cfg),
        .clear     (clear),
        .status    (status)
    );

    csr_axil u_csr (
        .clk_adder (clk_adder),
        .rstb      (rstb),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .cfg       (cfg),
        .clear     (clear),
        .status    (status)
    );

endmodule

/* verification/adc_backend_properties.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module adc_backend_properties (
    input logic                     clk_adder,
    input logic                     rstb,
    input logic                     tdc_valid,
    input adc_pkg::adc_cfg_t        cfg,
    input adc_pkg::adc_sample_t     sample,
    input logic                     bvalid,
    input logic                     bready,
    input logic                     rvalid,
    input logic                     rready,
    input logic [`ADC_AXI_DW-1:0]   rdata
);

    int fails = 0;   // failed assertions

    // three stage pipe without stall
    latency_a: assert property (@(posedge clk_adder) disable iff (!rstb)
        sample.valid == $past(tdc_valid && cfg.en, 3))
        else begin
            $error("sample.valid does not match an enabled tdc_valid 3 cycles earlier");
            fails++;
        end

    bvalid_hold_a: assert property (@(posedge clk_adder) disable iff (!rstb)
        bvalid && !bready |=> bvalid)
        else begin
            $error("bvalid dropped before bready");
            fails++;
        end

    rvalid_hold_a: assert property (@(posedge clk_adder) disable iff (!rstb)
        rvalid && !rready |=> rvalid && $stable(rdata))
        else begin
            $error("rvalid or rdata changed before rready");
            fails++;
        end

    reset_low_a: assert property (@(posedge clk_adder)
        !rstb |-> !sample.valid && !bvalid && !rvalid)
        else begin
            $error("valid output high during reset");
            fails++;
        end

    // magnitude tops out at 255 so the offset bounds both ends
    code_range_a: assert property (@(posedge clk_adder) disable iff (!rstb)
        sample.valid |-> int'(sample.code) <= 255 - int'($past(cfg.offset))
                         && int'(sample.code) >= -255 - int'($past(cfg.offset)))
        else begin
            $error("sample.code outside the range reachable with the offset");
            fails++;
        end

endmodule

bind adc_backend_top adc_backend_properties u_props (
    .clk_adder (clk_adder),
    .rstb      (rstb),
    .tdc_valid (tdc_valid),
    .cfg       (cfg),
    .sample    (sample),
    .bvalid    (bvalid),
    .bready    (bready),
    .rvalid    (rvalid),
    .rready    (rready),
    .rdata     (rdata)
);

/* verification/tb_adc_backend.sv */
`timescale 1ns/10ps
`include "adc_macros.svh"

module tb_adc_backend;

    localparam int TIMEOUT = 50;

    logic                           clk_adder;
    logic                           rstb;
    logic [`ADC_NTAPS-1:0]          tdc_taps;
    logic                           pfd_sign;
    logic                           tdc_valid;
    adc_pkg::adc_sample_t           sample;
    logic [`ADC_AXI_AW-1:0]         awaddr;
    logic                           awvalid;
    logic                           awready;
    logic [`ADC_AXI_DW-1:0]         wdata;
    logic [`ADC_AXI_DW/8-1:0]       wstrb;
    logic                           wvalid;
    logic                           wready;
    logic [1:0]                     bresp;
    logic                           bvalid;
    logic                           bready;
    logic [`ADC_AXI_AW-1:0]         araddr;
    logic                           arvalid;
    logic                           arready;
    logic [`ADC_AXI_DW-1:0]         rdata;
    logic [1:0]                     rresp;
    logic                           rvalid;
    logic                           rready;

    logic [15:0]                    lfsr = 16'd92;
    logic signed [`ADC_CODE_W-1:0]  exp_q [$];
    int                             rd_idx = 0;
    int                             sample_errors = 0;
    int                             reg_errors = 0;
    int                             timeouts = 0;
    logic                           m_en = 1'b0;
    logic                           m_phase_rev = 1'b0;
    int                             m_offset = 0;
    int                             m_sum = 0;
    logic signed [`ADC_CODE_W-1:0]  m_last = '0;

    adc_backend_top u_dut (.*);

    always #50 clk_adder = ~clk_adder;

    // galois form of x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    function automatic logic signed [`ADC_CODE_W-1:0] model_code(
        input logic [`ADC_NTAPS-1:0] t, input logic s);
        int n;
        int code;
        n = 0;
        for (int i = 0; i < `ADC_NTAPS; i++) begin
            if (t[i] != m_phase_rev) n++;   // zeros when reversed
        end
        code = (s ? n : -n) - m_offset;
        if (code > 255) code = 255;
        else if (code < -256) code = -256;
        return `ADC_CODE_W'(code);
    endfunction

    task automatic step();
        @(posedge clk_adder);
        #5;
    endtask

    task automatic finish_run();
        int prop_errors;
        prop_errors = u_dut.u_props.fails;
        $display("errors: sample %0d, register %0d, property %0d, timeout %0d",
                 sample_errors, reg_errors, prop_errors, timeouts);
        if (sample_errors + reg_errors + prop_errors + timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    task automatic abort_wait(input string what);
        timeouts++;
        $display("timeout: %s did not arrive within %0d cycles at %0t", what, TIMEOUT, $time);
        finish_run();
    endtask

    task automatic check_reg(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected) else begin
            reg_errors++;
            $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h",
                     $time, name, expected, actual);
        end
    endtask

    // compared at the falling edge where the pipe output is settled
    always @(negedge clk_adder) begin
        if (rstb && sample.valid) begin
            if (rd_idx >= exp_q.size()) begin
                sample_errors++;
                $display("unexpected sample at %0t, code %0d", $time, sample.code);
            end else begin
                assert (sample.code == exp_q[rd_idx]) else begin
                    sample_errors++;
                    $display("[ERROR] %0t sample.code expected %0d actual %0d",
                             $time, exp_q[rd_idx], sample.code);
                end
                rd_idx++;
            end
        end
    end

    task automatic convert(input logic [`ADC_NTAPS-1:0] t, input logic s);
        logic signed [`ADC_CODE_W-1:0] code;
        tdc_taps  = t;
        pfd_sign  = s;
        tdc_valid = 1'b1;
        if (m_en) begin
            code = model_code(t, s);
            exp_q.push_back(code);
            m_last = code;
            m_sum  = m_sum + int'(code);
        end
        step();
        tdc_valid = 1'b0;
    endtask

    task automatic random_burst(input int count);
        logic [`ADC_NTAPS-1:0] t;
        logic s;
        repeat (count) begin
            for (int i = 0; i < `ADC_NTAPS; i++) begin
                t[i] = lfsr[0];
                lfsr = lfsr_next(lfsr);
            end
            s = lfsr[0];
            lfsr = lfsr_next(lfsr);
            convert(t, s);
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (rd_idx < exp_q.size() && n < TIMEOUT) begin
            step();
            n++;
        end
        if (rd_idx < exp_q.size()) abort_wait("expected samples");
    endtask

    task automatic axi_write(input adc_pkg::csr_addr_e word, input logic [31:0] data,
                             input int hold);
        int n;
        awaddr  = {word, 2'b00};
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        @(negedge clk_adder);
        while (!awready && n < TIMEOUT) begin
            @(negedge clk_adder);
            n++;
        end
        if (!awready) begin
            abort_wait("awready");
        end else begin
            check_reg("wready", 32'd1, 32'(wready));   // accepted with aw
        end
        step();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        @(negedge clk_adder);
        while (!bvalid && n < TIMEOUT) begin
            @(negedge clk_adder);
            n++;
        end
        if (!bvalid) begin
            abort_wait("bvalid");
        end else begin
            check_reg("bresp", 32'd0, 32'(bresp));
        end
        repeat (hold) begin
            @(negedge clk_adder);
            check_reg("bvalid", 32'd1, 32'(bvalid));
        end
        step();
        bready = 1'b1;
        step();
        bready = 1'b0;
    endtask

    task automatic check_read(input string name, input adc_pkg::csr_addr_e word,
                              input logic [31:0] expected);
        int n;
        araddr  = {word, 2'b00};
        arvalid = 1'b1;
        n = 0;
        @(negedge clk_adder);
        while (!arready && n < TIMEOUT) begin
            @(negedge clk_adder);
            n++;
        end
        if (!arready) abort_wait("arready");
        step();
        arvalid = 1'b0;
        n = 0;
        @(negedge clk_adder);
        while (!rvalid && n < TIMEOUT) begin
            @(negedge clk_adder);
            n++;
        end
        if (!rvalid) begin
            abort_wait("rvalid");
        end else begin
            check_reg(name, expected, rdata);
            check_reg("rresp", 32'd0, 32'(rresp));
        end
        step();
        rready = 1'b1;
        step();
        rready = 1'b0;
    endtask

    task automatic write_ctrl(input logic en, input logic pr, input logic [2:0] log2,
                              input int hold);
        wait_drain();
        axi_write(adc_pkg::CSR_CTRL, {27'd0, log2, pr, en}, hold);
        m_en  = en;
        m_sum = 0;
        repeat (3) step();   // synchronizer settle
        m_phase_rev = pr;
    endtask

    task automatic write_offset(input int off);
        wait_drain();
        axi_write(adc_pkg::CSR_OFFSET, off, 0);
        m_offset = off;
    endtask

    initial begin
        int avg;
        clk_adder = 1'b0;
        rstb      = 1'b0;
        tdc_taps  = '0;
        pfd_sign  = 1'b0;
        tdc_valid = 1'b0;
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = 4'hF;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        repeat (16) @(posedge clk_adder);
        #5;
        rstb = 1'b1;
        step();

        write_ctrl(1'b1, 1'b0, 3'd0, 0);
        random_burst(32);

        // saturation at both ends
        write_offset(20);
        convert('1, 1'b1);
        convert('1, 1'b0);
        convert('0, 1'b0);
        random_burst(8);
        write_offset(-20);
        convert('1, 1'b1);
        convert('0, 1'b0);
        random_burst(8);

        write_offset(0);
        write_ctrl(1'b1, 1'b1, 3'd0, 0);
        convert('0, 1'b1);
        convert('1, 1'b1);
        random_burst(16);

        // block of eight
        write_ctrl(1'b1, 1'b0, 3'd3, 0);
        random_burst(8);
        wait_drain();
        avg = m_sum / 8;
        if (m_sum % 8 != 0 && m_sum < 0) avg = avg - 1;
        check_read("AVG", adc_pkg::CSR_AVG, avg);
        check_read("CTRL", adc_pkg::CSR_CTRL, 32'h8000_000D);   // avg_done, log2 3, en
        write_ctrl(1'b1, 1'b0, 3'd3, 0);
        check_read("CTRL", adc_pkg::CSR_CTRL, 32'h0000_000D);

        random_burst(4);
        write_ctrl(1'b0, 1'b0, 3'd0, 4);
        random_burst(6);
        repeat (8) step();
        check_read("SAMPLE", adc_pkg::CSR_SAMPLE, 32'(m_last));
        finish_run();
    end

endmodule

/* project.f */
+incdir+design
design/adc_pkg.sv
design/tdc_decode.sv
design/code_execute.sv
design/result_stage.sv
design/csr_axil.sv
design/adc_backend_top.sv
verification/adc_backend_properties.sv
verification/tb_adc_backend.sv

/* Makefile */
TOP := tb_adc_backend

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): project.f design/*.sv design/*.svh verification/*.sv
	verilator --binary --timing --assert --top-module $(TOP) -f project.f

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+1000)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir
